//--- Makefile
SIM = obj_dir/core_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module core_tb \
		-f compile.f -o core_sim

run: compile
	./$(SIM) | tee sim.log
	@grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- compile.f
+incdir+tb
hdl/core_pkg.sv
hdl/inst_decode.sv
hdl/reg_file.sv
hdl/execute_unit.sv
hdl/core_top.sv
tb/core_tb.sv

//--- hdl/core_pkg.sv
package core_pkg;

	// data word, also register values and alu operands
	typedef logic [31:0] xlen_t;
	// byte address of an instruction
	typedef logic [31:0] addr_t;
	// raw instruction word
	typedef logic [31:0] inst_t;
	// architectural register index
	typedef logic [4:0]  reg_idx_t;

	// alu operations, order follows the OP group
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	// major opcodes handled by the core
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111
	} opcode_e;

	// decoded instruction, consumed by the execute unit
	typedef struct packed {
		alu_op_e alu_op;
		// operand a from pc instead of rs1
		logic    src_a_pc;
		// operand b from the immediate instead of rs2
		logic    src_b_imm;
		// operand a forced to zero, lui
		logic    zero_a;
		// result is pc+4, next pc is the alu sum
		logic    link;
		// jalr target drops bit 0
		logic    clear_lsb;
		logic    reg_write;
		logic    illegal;
	} ctrl_t;

	// per-instruction trace at the top level
	typedef struct packed {
		logic     valid;
		addr_t    pc;
		inst_t    inst;
		reg_idx_t rd;
		xlen_t    wdata;
		logic     we;
		logic     illegal;
	} retire_t;

endpackage

//--- hdl/core_top.sv
module core_top import core_pkg::*; #(
	parameter addr_t reset_pc = 32'h0000_0000
) (
	input  logic    clk,
	input  logic    arst_n,
	input  inst_t   inst,
	output addr_t   pc,
	output retire_t retire
);

	// decoder outputs
	ctrl_t    ctrl;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	xlen_t    imm;
	// register file read data
	xlen_t    rs1_data;
	xlen_t    rs2_data;
	// writeback, shared by reg_file and retire
	xlen_t    wdata;
	logic     we;

	// decode and register read side by side on the same word
	inst_decode u_decode (
		.inst (inst),
		.ctrl (ctrl),
		.rd   (rd),
		.rs1  (rs1),
		.rs2  (rs2),
		.imm  (imm)
	);

	reg_file u_reg_file (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs1      (rs1),
		.rs2      (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.we       (we),
		.rd       (rd),
		.wdata    (wdata)
	);

	// alu, writeback value and pc register
	execute_unit #(
		.reset_pc (reset_pc)
	) u_execute (
		.clk      (clk),
		.arst_n   (arst_n),
		.ctrl     (ctrl),
		.imm      (imm),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.pc       (pc),
		.wdata    (wdata),
		.we       (we)
	);

	// trace of the instruction that commits at the next edge
	// valid follows reset release, one retire per cycle after that
	assign retire = '{
		valid:   arst_n,
		pc:      pc,
		inst:    inst,
		rd:      rd,
		wdata:   wdata,
		we:      we,
		illegal: ctrl.illegal
	};

endmodule

//--- hdl/execute_unit.sv
module execute_unit import core_pkg::*; #(
	parameter addr_t reset_pc = 32'h0000_0000
) (
	input  logic  clk,
	input  logic  arst_n,
	input  ctrl_t ctrl,
	input  xlen_t imm,
	input  xlen_t rs1_data,
	input  xlen_t rs2_data,
	output addr_t pc,
	output xlen_t wdata,
	output logic  we
);

	xlen_t      op_a;
	xlen_t      op_b;
	xlen_t      sum;
	xlen_t      alu_result;
	addr_t      pc_plus4;
	addr_t      next_pc;
	logic [4:0] shamt;

	// operand a: zero for lui, pc for auipc / jal, else rs1
	assign op_a = ctrl.zero_a ? '0 : (ctrl.src_a_pc ? pc : rs1_data);
	// operand b: immediate or rs2
	assign op_b = ctrl.src_b_imm ? imm : rs2_data;
	// only low five bits shift
	assign shamt = op_b[4:0];

	// sum shared by add and jump target
	assign sum = op_a + op_b;
	assign pc_plus4 = pc + 32'd4;

	always_comb begin
		case (ctrl.alu_op)
			alu_add:  alu_result = sum;
			alu_sub:  alu_result = op_a - op_b;
			alu_sll:  alu_result = op_a << shamt;
			alu_slt:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
			alu_sltu: alu_result = {31'b0, op_a < op_b};
			alu_xor:  alu_result = op_a ^ op_b;
			alu_srl:  alu_result = op_a >> shamt;
			// arithmetic shift keeps the sign
			alu_sra:  alu_result = xlen_t'($signed(op_a) >>> shamt);
			alu_or:   alu_result = op_a | op_b;
			alu_and:  alu_result = op_a & op_b;
			default:  alu_result = sum;
		endcase
	end

	// jumps write the return address
	assign wdata = ctrl.link ? pc_plus4 : alu_result;
	// rd 0 already folded into reg_write by the decoder
	assign we = ctrl.reg_write;

	// jump target from the sum, jalr clears bit 0
	assign next_pc = ctrl.link ? {sum[31:1], sum[0] & ~ctrl.clear_lsb} : pc_plus4;

	// one instruction per edge, no stall
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= reset_pc;
		end else begin
			pc <= next_pc;
		end
	end

	// aligned reset value and aligned targets keep pc aligned
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!arst_n)
		pc[1:0] == 2'b00
	) else $error("pc %h not word aligned", pc);

endmodule

//--- hdl/inst_decode.sv
module inst_decode import core_pkg::*; (
	input  inst_t    inst,
	output ctrl_t    ctrl,
	output reg_idx_t rd,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	output xlen_t    imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       f7_zero;
	logic       f7_alt;
	logic       is_op;
	logic       op_ok;
	logic       imm_ok;
	logic       low_ok;
	xlen_t      imm_i;
	xlen_t      imm_u;
	xlen_t      imm_j;
	alu_op_e    alu_sel;

	// fixed instruction fields
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd     = inst[11:7];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];

	// immediate formats, all sign extended from bit 31
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	assign f7_zero = (funct7 == 7'b0000000);
	assign f7_alt  = (funct7 == 7'b0100000);
	assign is_op   = (opcode == opc_op);
	// 32-bit encodings only
	assign low_ok  = (inst[1:0] == 2'b11);

	// register form: alt funct7 only for sub and sra
	assign op_ok  = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
	// immediate form: upper bits checked on shifts only
	assign imm_ok = (funct3 != 3'b001 && funct3 != 3'b101) || f7_zero ||
		(f7_alt && funct3 == 3'b101);

	// funct3 to alu op, funct7 bit 30 picks sub / sra
	always_comb begin
		case (funct3)
			3'b000: alu_sel = (is_op && f7_alt) ? alu_sub : alu_add;
			3'b001: alu_sel = alu_sll;
			3'b010: alu_sel = alu_slt;
			3'b011: alu_sel = alu_sltu;
			3'b100: alu_sel = alu_xor;
			3'b101: alu_sel = f7_alt ? alu_sra : alu_srl;
			3'b110: alu_sel = alu_or;
			default: alu_sel = alu_and;
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = alu_add;
		imm = imm_i;
		case (opcode)
			opc_op: begin
				ctrl.alu_op = alu_sel;
				ctrl.illegal = !op_ok;
			end
			opc_op_imm: begin
				ctrl.alu_op = alu_sel;
				ctrl.src_b_imm = 1'b1;
				ctrl.illegal = !imm_ok;
			end
			opc_lui: begin
				// 0 + imm_u
				ctrl.zero_a = 1'b1;
				ctrl.src_b_imm = 1'b1;
				imm = imm_u;
			end
			opc_auipc: begin
				ctrl.src_a_pc = 1'b1;
				ctrl.src_b_imm = 1'b1;
				imm = imm_u;
			end
			opc_jal: begin
				// target is pc + imm_j
				ctrl.src_a_pc = 1'b1;
				ctrl.src_b_imm = 1'b1;
				ctrl.link = 1'b1;
				imm = imm_j;
			end
			opc_jalr: begin
				// target is rs1 + imm_i, lsb dropped
				ctrl.src_b_imm = 1'b1;
				ctrl.link = 1'b1;
				ctrl.clear_lsb = 1'b1;
				ctrl.illegal = (funct3 != 3'b000);
			end
			default: ctrl.illegal = 1'b1;
		endcase
		if (!low_ok)
			ctrl.illegal = 1'b1;
		// illegal word retires as a plain pc+4 step
		if (ctrl.illegal) begin
			ctrl.link = 1'b0;
			ctrl.clear_lsb = 1'b0;
		end
		// rd 0 is no architectural write
		ctrl.reg_write = !ctrl.illegal && (rd != '0);
	end

endmodule

//--- hdl/reg_file.sv
module reg_file import core_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	output xlen_t    rs1_data,
	output xlen_t    rs2_data,
	input  logic     we,
	input  reg_idx_t rd,
	input  xlen_t    wdata
);

	// x0 is an entry that is cleared by reset and never written
	xlen_t regs [0:31];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != '0) begin
			// writes to x0 dropped here
			regs[rd] <= wdata;
		end
	end

	// combinational reads straight from the array
	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];

	// x0 reads zero on both ports whatever was written before
	a_x0_rs1: assert property (
		@(posedge clk) disable iff (!arst_n)
		(rs1 == '0) |-> (rs1_data == '0)
	) else $error("x0 read on port 1 returned %h", rs1_data);

	a_x0_rs2: assert property (
		@(posedge clk) disable iff (!arst_n)
		(rs2 == '0) |-> (rs2_data == '0)
	) else $error("x0 read on port 2 returned %h", rs2_data);

endmodule

//--- tb/ref_model.svh
// instruction-level model of the core, plus the program generator

// result of one reference step
typedef struct packed {
	logic  ill;
	logic  wr;
	xlen_t res;
	addr_t npc;
} step_t;

// xorshift32 step
function automatic logic [31:0] next_rand(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x ^= x << 13;
	x ^= x >> 17;
	x ^= x << 5;
	return x;
endfunction

// rv32i integer ops by funct3, alt picks sub / sra
function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt, input xlen_t x,
		input xlen_t y);
	case (f3)
		3'd0: return alt ? x - y : x + y;
		3'd1: return x << y[4:0];
		3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
		3'd3: return (x < y) ? 32'd1 : 32'd0;
		3'd4: return x ^ y;
		3'd5: return alt ? xlen_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
		3'd6: return x | y;
		default: return x & y;
	endcase
endfunction

// one instruction against the model state
function automatic step_t ref_exec(input inst_t w, input addr_t cur_pc, input xlen_t a,
		input xlen_t b);
	step_t s;
	logic [2:0] f3;
	logic [6:0] f7;
	xlen_t imm_i;
	f3 = w[14:12];
	f7 = w[31:25];
	imm_i = {{20{w[31]}}, w[31:20]};
	s.ill = 1'b0;
	s.res = '0;
	s.npc = cur_pc + 32'd4;
	case (w[6:0])
		7'b0110011: begin
			s.ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
			s.res = alu_ref(f3, f7[5], a, b);
		end
		7'b0010011: begin
			// upper bits only matter for shifts
			if (f3 == 3'd1)
				s.ill = (f7 != 7'h00);
			else if (f3 == 3'd5)
				s.ill = (f7 != 7'h00 && f7 != 7'h20);
			s.res = alu_ref(f3, f3 == 3'd5 && f7[5], a, imm_i);
		end
		7'b0110111: s.res = {w[31:12], 12'b0};
		7'b0010111: s.res = cur_pc + {w[31:12], 12'b0};
		7'b1101111: begin
			s.res = cur_pc + 32'd4;
			s.npc = cur_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		end
		7'b1100111: begin
			s.ill = (f3 != 3'd0);
			s.res = cur_pc + 32'd4;
			s.npc = (a + imm_i) & ~32'd1;
		end
		default: s.ill = 1'b1;
	endcase
	// illegal words just step
	if (s.ill)
		s.npc = cur_pc + 32'd4;
	s.wr = !s.ill && (w[11:7] != 5'd0);
	return s;
endfunction

// random word from two random values, kind in a[3:0]
function automatic inst_t gen_word(input logic [31:0] a, input logic [31:0] b);
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [2:0] f3;
	logic [6:0] f7;
	logic [20:0] j;
	logic [6:0] unk;
	inst_t w;
	// few registers, so results feed later ops
	rd = {2'b00, b[9:7]};
	rs1 = {2'b00, b[12:10]};
	rs2 = {2'b00, b[15:13]};
	f3 = b[2:0];
	f7 = (b[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
	// word-aligned jal offset
	j = {b[31:13], 2'b00};
	case (b[1:0])
		2'd0: unk = 7'b0000011;
		2'd1: unk = 7'b0100011;
		2'd2: unk = 7'b1100011;
		default: unk = 7'b1110011;
	endcase
	case (a[3:0])
		4'd0, 4'd1, 4'd2, 4'd3, 4'd4: w = {f7, rs2, rs1, f3, rd, 7'b0110011};
		4'd5, 4'd6, 4'd7, 4'd8: begin
			if (f3 == 3'd1 || f3 == 3'd5)
				w = {f7, b[24:20], rs1, f3, rd, 7'b0010011};
			else
				w = {b[31:20], rs1, f3, rd, 7'b0010011};
		end
		4'd9: w = {b[31:12], rd, 7'b0110111};
		4'd10: w = {b[31:12], rd, 7'b0010111};
		4'd11: w = {j[20], j[10:1], j[11], j[19:12], rd, 7'b1101111};
		// x31 is the jalr base, bit 0 of the offset may be set
		4'd12: w = {b[31:22], 1'b0, b[16], 5'd31, 3'b000, rd, 7'b1100111};
		4'd13: w = {b[31:2], (b[1:0] == 2'b11) ? 2'b00 : b[1:0]};
		// multiply extension or slli with reserved upper bits, neither supported
		4'd14: begin
			if (b[4])
				w = {7'h01, rs2, rs1, f3, rd, 7'b0110011};
			else
				w = {7'h20, b[24:20], rs1, 3'b001, rd, 7'b0010011};
		end
		default: w = {b[31:7], unk};
	endcase
	return w;
endfunction

//--- tb/core_tb.sv
module core_tb import core_pkg::*; ();

	localparam addr_t reset_pc = 32'h0000_0200;
	localparam int prog_len = 256;
	localparam int timeout = (prog_len + 10) * 4;

	logic    clk = 1'b1;
	logic    arst_n = 1'b1;
	// nop until the first fetch
	inst_t   inst = 32'h0000_0013;
	addr_t   pc;
	retire_t retire;

	`include "ref_model.svh"

	inst_t       prog [0:prog_len-1];
	// shadow registers and pc of the model
	xlen_t       shadow [0:31];
	addr_t       model_pc = reset_pc;
	step_t       expected;
	int          errors = 0;
	int          retired = 0;
	int          illegal_cnt = 0;
	int          jump_cnt = 0;
	int          test_errors;
	logic [31:0] seed;
	logic [31:0] rnd_a;

	core_top #(
		.reset_pc (reset_pc)
	) uut (
		.clk    (clk),
		.arst_n (arst_n),
		.inst   (inst),
		.pc     (pc),
		.retire (retire)
	);

	always #2 clk = ~clk;

	// fetch by model pc, a wrong dut pc then shows on retire.pc
	always @(negedge clk) begin
		inst <= prog[model_pc[9:2]];
	end

	always_comb begin
		expected = ref_exec(inst, model_pc, shadow[inst[19:15]], shadow[inst[24:20]]);
	end

	// model steps with the core, one word per edge
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			model_pc <= reset_pc;
			for (int i = 0; i < 32; i++) begin
				shadow[i] <= '0;
			end
		end else begin
			model_pc <= expected.npc;
			if (expected.wr)
				shadow[inst[11:7]] <= expected.res;
			retired <= retired + 1;
			if (expected.ill)
				illegal_cnt <= illegal_cnt + 1;
			if (!expected.ill && (inst[6:0] == 7'b1101111 || inst[6:0] == 7'b1100111))
				jump_cnt <= jump_cnt + 1;
		end
	end

	a_reset: assert property (@(posedge clk) !arst_n |-> (pc == reset_pc && !retire.valid))
	else begin
		$display("** Error: %0t: in reset pc %h valid %b", $time, $sampled(pc),
			$sampled(retire.valid));
		errors++;
	end

	// covers the first pc after release and every jump target
	a_pc: assert property (@(posedge clk) disable iff (!arst_n)
		retire.valid && retire.pc == model_pc)
	else begin
		$display("** Error: %0t: retire pc %h valid %b, expected pc %h", $time,
			$sampled(retire.pc), $sampled(retire.valid), $sampled(model_pc));
		errors++;
	end

	// trace names the fetched word, its rd field and the core pc
	a_trace: assert property (@(posedge clk) disable iff (!arst_n)
		retire.inst == inst && retire.rd == inst[11:7] && pc == model_pc)
	else begin
		$display("** Error: %0t: trace inst %h rd %0d pc %h, expected %h at %h", $time,
			$sampled(retire.inst), $sampled(retire.rd), $sampled(pc), $sampled(inst),
			$sampled(model_pc));
		errors++;
	end

	a_illegal: assert property (@(posedge clk) disable iff (!arst_n)
		retire.illegal == expected.ill)
	else begin
		$display("** Error: %0t: illegal flag %b for %h", $time, $sampled(retire.illegal),
			$sampled(inst));
		errors++;
	end

	// rd 0 and illegal words must keep we low
	a_we: assert property (@(posedge clk) disable iff (!arst_n) retire.we == expected.wr)
	else begin
		$display("** Error: %0t: we %b for %h", $time, $sampled(retire.we), $sampled(inst));
		errors++;
	end

	a_wdata: assert property (@(posedge clk) disable iff (!arst_n)
		expected.wr |-> retire.wdata == expected.res)
	else begin
		$display("** Error: %0t: wdata %h for %h, expected %h", $time,
			$sampled(retire.wdata), $sampled(inst), $sampled(expected.res));
		errors++;
	end

	initial begin
		seed = 32'hf3cd_22d3;
		for (int i = 0; i < prog_len; i++) begin
			seed = next_rand(seed);
			rnd_a = seed;
			seed = next_rand(seed);
			prog[i] = gen_word(rnd_a, seed);
		end
		// lui x31 then addi x31, base 0xe00 for every jalr
		prog[reset_pc[9:2]] = {20'h00001, 5'd31, 7'b0110111};
		prog[reset_pc[9:2] + 8'd1] = {12'he00, 5'd31, 3'b000, 5'd31, 7'b0010011};
		@(negedge clk);
		arst_n = 1'b0;
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		$display("reset test done, %0d errors", errors);
		test_errors = errors;
		while (retired < prog_len)
			@(posedge clk);
		@(negedge clk);
		$display("program test done, %0d retired, %0d errors", retired, errors - test_errors);
		$display("retired %0d, illegal %0d, jumps %0d, errors %0d", retired, illegal_cnt,
			jump_cnt, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// whole program plus slack for reset
	initial begin
		#(timeout);
		$display("run timed out after %0d time units with %0d of %0d instructions retired",
			timeout, retired, prog_len);
		$display("Test failed");
		$finish;
	end

endmodule
